//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_fetch
FILELIST  := sim.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)

SRCS      := $(shell grep -v '^+' $(FILELIST))
DATA      := sim/fetch_tests.txt

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN) $(DATA)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- sim.f
verilog/fetch_pkg.sv
verilog/inst_addr_map.sv
verilog/pre_if_stage.sv
verilog/if_stage.sv
verilog/fetch_unit.sv
sim/tb_fetch.sv

//--- sim/fetch_tests.txt
# name kind trigger_pc target_or_epc then the next three pcs delivered after the trigger
# kind B branch, BS branch under br_stall, MS branch under mfc0_stall, F flush, E eret, FE both
branch_kseg1      B  bfc00010 bfc00100 bfc00014 bfc00100 bfc00104
branch_br_stall   BS bfc00108 bfc00800 bfc0010c bfc00110 bfc00114
branch_mfc0_stall MS bfc00118 bfc00800 bfc0011c bfc00120 bfc00124
flush_kseg1       F  bfc00128 00000000 bfc00380 bfc00384 bfc00388
eret_kseg1        E  bfc00390 bfc00200 bfc00200 bfc00204 bfc00208
flush_and_eret    FE bfc00210 bfc00300 bfc00300 bfc00304 bfc00308
branch_to_kseg0   B  bfc00310 80001000 bfc00314 80001000 80001004
branch_to_kuseg   B  80001010 00400000 80001014 00400000 00400004
flush_from_kuseg  F  00400020 00000000 bfc00380 bfc00384 bfc00388
eret_to_kseg0     E  bfc003a0 9fc00040 9fc00040 9fc00044 9fc00048
branch_back_reset B  9fc00060 bfc00000 9fc00064 bfc00000 bfc00004

//--- sim/tb_fetch.sv
`timescale 1ns/1ps

module tb_fetch
    import fetch_pkg::*;
();

    logic        clk;
    logic        reset;
    logic        br_stall;
    logic        br_taken;
    logic [31:0] br_target;
    logic        flush;
    logic        m1s_inst_eret;
    logic [31:0] cp0_epc;
    logic        mfc0_stall;
    logic        ds_allowin;
    logic        ds_valid;
    logic [31:0] ds_pc;
    logic [31:0] ds_inst;
    logic        inst_req;
    logic        inst_op;
    logic [19:0] inst_tag;
    logic [ 7:0] inst_index;
    logic [ 3:0] inst_offset;
    logic        inst_uncached;
    logic        inst_addr_ok;
    logic        inst_data_ok;
    logic [31:0] inst_rdata;

    // test table from the data file
    string       t_name [32];
    string       t_kind [32];
    logic [31:0] t_trig [32];
    logic [31:0] t_targ [32];
    logic [31:0] t_seq  [32][3];
    int          num_tests;

    int          ti;             // next test to arm
    int          seq_test;
    int          seq_pos;        // 3 when no sequence is being checked
    bit          ev_pend;
    bit          ev_now;
    bit          trig_now;
    logic [31:0] dq [$];         // accepted pcs still owed to decode
    logic [31:0] rsp_data [$];
    int          rsp_due [$];
    logic [31:0] exp_issue_pc;
    int          cycle;
    int          idle;
    int          tail_cnt;
    string       cur_name;
    bit          prev_stall;
    logic [31:0] prev_pc;
    logic [31:0] prev_inst;

    fetch_unit UUT (
        .clk           (clk),
        .reset         (reset),
        .br_stall      (br_stall),
        .br_taken      (br_taken),
        .br_target     (br_target),
        .flush         (flush),
        .m1s_inst_eret (m1s_inst_eret),
        .cp0_epc       (cp0_epc),
        .mfc0_stall    (mfc0_stall),
        .ds_allowin    (ds_allowin),
        .ds_valid      (ds_valid),
        .ds_pc         (ds_pc),
        .ds_inst       (ds_inst),
        .inst_req      (inst_req),
        .inst_op       (inst_op),
        .inst_tag      (inst_tag),
        .inst_index    (inst_index),
        .inst_offset   (inst_offset),
        .inst_uncached (inst_uncached),
        .inst_addr_ok  (inst_addr_ok),
        .inst_data_ok  (inst_data_ok),
        .inst_rdata    (inst_rdata)
    );

    always #5 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("Error: %s", msg);
        $display("Regression failed");
        $fatal(1, "%s", msg);
    endtask

    task automatic check_pc(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("Fail %s expected pc %h actual %h", name, exp, act);
            $display("Regression failed");
            $fatal(1, "pc mismatch");
        end
    endtask

    task automatic check_inst(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("Fail %s expected inst %h actual %h", name, exp, act);
            $display("Regression failed");
            $fatal(1, "instruction mismatch");
        end
    endtask

    task automatic check_paddr(input string name, input paddr_u exp, input paddr_u act);
        if (act.raw !== exp.raw) begin
            $display("Fail %s expected paddr %h actual %h", name, exp.raw, act.raw);
            $display("Regression failed");
            $fatal(1, "request address mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail %s expected flag %b actual %b", name, exp, act);
            $display("Regression failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    // kseg0 and kseg1 both alias the low 512 MB
    function automatic paddr_u expect_paddr(input logic [31:0] pc);
        paddr_u p;
        if (pc[31:30] == 2'b10)
            p.raw = {3'b000, pc[28:0]};
        else
            p.raw = pc;
        return p;
    endfunction

    task automatic load_tests();
        int          fd;
        int          rc;
        string       line;
        string       nm;
        string       kd;
        logic [31:0] v [5];
        fd = $fopen("sim/fetch_tests.txt", "r");
        if (fd == 0)
            report_failure("cannot open sim/fetch_tests.txt");
        num_tests = 0;
        while (!$feof(fd)) begin
            line = "";
            rc = $fgets(line, fd);
            if (rc > 0 && line.len() > 1 && line.getc(0) != 8'h23) begin   // skip # lines
                rc = $sscanf(line, "%s %s %h %h %h %h %h", nm, kd, v[0], v[1], v[2], v[3], v[4]);
                if (rc == 7 && num_tests < 32) begin
                    t_name[num_tests] = nm;
                    t_kind[num_tests] = kd;
                    t_trig[num_tests] = v[0];
                    t_targ[num_tests] = v[1];
                    t_seq[num_tests][0] = v[2];
                    t_seq[num_tests][1] = v[3];
                    t_seq[num_tests][2] = v[4];
                    num_tests++;
                end
            end
        end
        $fclose(fd);
        if (num_tests == 0)
            report_failure("no tests found in sim/fetch_tests.txt");
    endtask

    task automatic apply_event(input int i);
        br_target = t_targ[i];
        cp0_epc   = t_targ[i];
        if (t_kind[i] == "B") begin
            br_taken = 1'b1;
        end else if (t_kind[i] == "BS") begin
            br_taken = 1'b1;
            br_stall = 1'b1;
        end else if (t_kind[i] == "MS") begin
            br_taken   = 1'b1;
            mfc0_stall = 1'b1;
        end else if (t_kind[i] == "F") begin
            flush = 1'b1;
        end else if (t_kind[i] == "E") begin
            m1s_inst_eret = 1'b1;
        end else if (t_kind[i] == "FE") begin
            flush         = 1'b1;
            m1s_inst_eret = 1'b1;
        end else begin
            report_failure({"unknown event kind in test ", t_name[i]});
        end
    endtask

    // inputs for the next rising edge
    task automatic drive_inputs();
        br_taken      = 1'b0;
        br_stall      = 1'b0;
        mfc0_stall    = 1'b0;
        flush         = 1'b0;
        m1s_inst_eret = 1'b0;
        ds_allowin    = ($urandom % 10) < 7;
        inst_addr_ok  = ($urandom % 10) < 6;
        trig_now      = 1'b0;
        ev_now        = 1'b0;
        if (ev_pend) begin
            apply_event(seq_test);
            ev_now  = 1'b1;
            ev_pend = 1'b0;
        end else if (ti < num_tests && ds_valid && ds_pc == t_trig[ti]) begin
            if (dq.size() < 2) begin
                ds_allowin = 1'b0;      // hold trigger until the delay slot is requested
            end else begin
                ds_allowin   = 1'b1;
                inst_addr_ok = 1'b0;    // nothing past the delay slot yet
                trig_now     = 1'b1;
            end
        end
        // in-order responder
        inst_data_ok = 1'b0;
        inst_rdata   = 32'h0;
        if (rsp_due.size() > 0 && cycle >= rsp_due[0]) begin
            inst_data_ok = 1'b1;
            inst_rdata   = rsp_data.pop_front();
            void'(rsp_due.pop_front());
        end
    endtask

    task automatic sample_outputs();
        logic   kill;
        paddr_u exp_p;
        paddr_u act_p;
        kill = flush | m1s_inst_eret;
        if (kill)
            check_flag(cur_name, 1'b0, ds_valid);
        if (prev_stall && !kill) begin
            check_flag(cur_name, 1'b1, ds_valid);
            check_pc(cur_name, prev_pc, ds_pc);
            check_inst(cur_name, prev_inst, ds_inst);
        end
        if (ds_valid && ds_allowin) begin
            if (dq.size() == 0)
                report_failure("decode received an instruction that was never requested");
            check_pc(cur_name, dq[0], ds_pc);
            void'(dq.pop_front());
            exp_p = expect_paddr(ds_pc);
            check_inst(cur_name, exp_p.raw ^ 32'h5a5a_0000, ds_inst);
            if (seq_pos < 3) begin
                check_pc(cur_name, t_seq[seq_test][seq_pos], ds_pc);
                seq_pos++;
            end
            if (trig_now) begin
                seq_test = ti;
                cur_name = t_name[ti];
                seq_pos  = 0;
                ev_pend  = 1'b1;
                ti++;
            end else if (ti == num_tests && seq_pos == 3) begin
                tail_cnt++;
            end
            idle = 0;
        end
        if (ev_now) begin
            if (m1s_inst_eret) begin
                exp_issue_pc = cp0_epc;
                dq.delete();
            end else if (flush) begin
                exp_issue_pc = exc_vector;
                dq.delete();
            end else if (br_taken && !br_stall && !mfc0_stall) begin
                exp_issue_pc = br_target;
            end
        end
        if (inst_req && inst_addr_ok) begin
            exp_p      = expect_paddr(exp_issue_pc);
            act_p.raw  = {inst_tag, inst_index, inst_offset};
            check_paddr(cur_name, exp_p, act_p);
            check_flag(cur_name, exp_issue_pc[31:29] == 3'b101, inst_uncached);
            check_flag(cur_name, 1'b0, inst_op);
            dq.push_back(exp_issue_pc);
            rsp_data.push_back(exp_p.raw ^ 32'h5a5a_0000);
            rsp_due.push_back(cycle + 1 + int'($urandom % 4));
            exp_issue_pc = exp_issue_pc + 32'd4;
        end
        prev_stall = ds_valid && !ds_allowin;
        prev_pc    = ds_pc;
        prev_inst  = ds_inst;
    endtask

    initial begin
        clk           = 1'b0;
        reset         = 1'b1;
        br_stall      = 1'b0;
        br_taken      = 1'b0;
        br_target     = 32'h0;
        flush         = 1'b0;
        m1s_inst_eret = 1'b0;
        cp0_epc       = 32'h0;
        mfc0_stall    = 1'b0;
        ds_allowin    = 1'b0;
        inst_addr_ok  = 1'b0;
        inst_data_ok  = 1'b0;
        inst_rdata    = 32'h0;
        void'($urandom(32'hbf219644));
        ti            = 0;
        seq_test      = 0;
        seq_pos       = 3;
        ev_pend       = 1'b0;
        cycle         = 0;
        idle          = 0;
        tail_cnt      = 0;
        prev_stall    = 1'b0;
        prev_pc       = 32'h0;
        prev_inst     = 32'h0;
        cur_name      = "reset_fetch";
        exp_issue_pc  = reset_vector;
        load_tests();

        repeat (3) begin
            @(posedge clk);
            #1;
            check_flag("reset", 1'b0, inst_req);
            check_flag("reset", 1'b0, ds_valid);
        end
        @(negedge clk);
        reset = 1'b0;

        while (!(ti == num_tests && tail_cnt >= 40)) begin
            drive_inputs();
            #2;
            sample_outputs();
            idle++;
            if (idle > 200)
                report_failure("timeout, no instruction reached decode for 200 cycles");
            @(negedge clk);
            cycle++;
        end

        $display("Regression passed");
        $finish;
    end

endmodule

//--- verilog/fetch_pkg.sv
package fetch_pkg;

    // fetch addresses
    localparam logic [31:0] reset_vector  = 32'hbfc0_0000;
    localparam logic [31:0] exc_vector    = 32'hbfc0_0380;   // general exception entry, BEV=1

    // fs_pc starts one word low so the sequential path lands on reset_vector
    localparam logic [31:0] reset_pc_init = reset_vector - 32'd4;

    // segment bounds of the fixed map
    localparam logic [31:0] kseg0_base    = 32'h8000_0000;   // cached, unmapped
    localparam logic [31:0] kseg1_base    = 32'ha000_0000;   // uncached, unmapped
    localparam logic [31:0] kseg2_base    = 32'hc000_0000;   // end of the unmapped window

    // top three bits, cleared for kseg0 and kseg1
    localparam logic [31:0] seg_mask      = 32'he000_0000;

    // accepted requests that may still be waiting for data
    localparam int max_in_flight = 2;

    // sizes of the in-flight bookkeeping in the IF stage
    localparam int flight_ptr_w  = $clog2(max_in_flight);
    localparam int flight_cnt_w  = $clog2(max_in_flight + 1);

    // physical fetch address
    // written whole by the address map, read back as cache fields
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [19:0] tag;
            logic [ 7:0] index;      // 256 sets
            logic [ 3:0] offset;     // 16-byte line
        } fields;
    } paddr_u;

endpackage

//--- verilog/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic        clk,
    input  logic        reset,
    // branch from decode
    input  logic        br_stall,
    input  logic        br_taken,
    input  logic [31:0] br_target,
    // exception and return
    input  logic        flush,
    input  logic        m1s_inst_eret,
    input  logic [31:0] cp0_epc,
    input  logic        mfc0_stall,
    // decode
    input  logic        ds_allowin,
    output logic        ds_valid,
    output logic [31:0] ds_pc,
    output logic [31:0] ds_inst,
    // instruction cache
    output logic        inst_req,
    output logic        inst_op,
    output logic [19:0] inst_tag,
    output logic [ 7:0] inst_index,
    output logic [ 3:0] inst_offset,
    output logic        inst_uncached,
    input  logic        inst_addr_ok,
    input  logic        inst_data_ok,
    input  logic [31:0] inst_rdata
);

    logic [31:0] next_pc;
    logic        req_fire;
    logic        fs_allowin;
    logic [31:0] fs_pc;

    pre_if_stage u_pre_if (
        .clk           (clk),
        .reset         (reset),
        .fs_pc         (fs_pc),
        .fs_allowin    (fs_allowin),
        .br_stall      (br_stall),
        .br_taken      (br_taken),
        .br_target     (br_target),
        .flush         (flush),
        .m1s_inst_eret (m1s_inst_eret),
        .cp0_epc       (cp0_epc),
        .mfc0_stall    (mfc0_stall),
        .inst_addr_ok  (inst_addr_ok),
        .next_pc       (next_pc),
        .req_fire      (req_fire),
        .inst_req      (inst_req),
        .inst_op       (inst_op),
        .inst_tag      (inst_tag),
        .inst_index    (inst_index),
        .inst_offset   (inst_offset),
        .inst_uncached (inst_uncached)
    );

    if_stage u_if (
        .clk           (clk),
        .reset         (reset),
        .next_pc       (next_pc),
        .req_fire      (req_fire),
        .flush         (flush),
        .m1s_inst_eret (m1s_inst_eret),
        .inst_data_ok  (inst_data_ok),
        .inst_rdata    (inst_rdata),
        .ds_allowin    (ds_allowin),
        .fs_allowin    (fs_allowin),
        .fs_pc         (fs_pc),
        .ds_valid      (ds_valid),
        .ds_pc         (ds_pc),
        .ds_inst       (ds_inst)
    );

endmodule

//--- verilog/if_stage.sv
`timescale 1ns/1ps

module if_stage
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] next_pc,
    input  logic        req_fire,
    input  logic        flush,
    input  logic        m1s_inst_eret,
    input  logic        inst_data_ok,
    input  logic [31:0] inst_rdata,
    input  logic        ds_allowin,
    output logic        fs_allowin,
    output logic [31:0] fs_pc,
    output logic        ds_valid,
    output logic [31:0] ds_pc,
    output logic [31:0] ds_inst
);

    // in-order slots, pc written on issue, instruction on response
    logic [31:0]             pc_q   [max_in_flight];
    logic [31:0]             inst_q [max_in_flight];
    logic [flight_ptr_w-1:0] wr_ptr;       // next issue slot
    logic [flight_ptr_w-1:0] rsp_ptr;      // next slot to receive data
    logic [flight_ptr_w-1:0] rd_ptr;       // head for decode
    logic [flight_cnt_w-1:0] pend_cnt;     // live, data not back yet
    logic [flight_cnt_w-1:0] rdy_cnt;      // data back, not yet taken by decode
    logic [flight_cnt_w-1:0] cancel_cnt;   // responses to drop after a flush
    logic [flight_cnt_w-1:0] busy;
    logic                    kill;
    logic                    rsp_live;
    logic                    pop;

    assign kill     = flush | m1s_inst_eret;
    assign rsp_live = inst_data_ok & (cancel_cnt == '0) & ~kill;
    assign pop      = ds_valid & ds_allowin;

    // a slot freed by decode this cycle can take a new request at once
    assign busy       = pend_cnt + rdy_cnt + cancel_cnt;
    assign fs_allowin = (busy < flight_cnt_w'(max_in_flight)) | pop;

    assign ds_valid = (rdy_cnt != '0) & ~kill;
    assign ds_pc    = pc_q[rd_ptr];
    assign ds_inst  = inst_q[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr     <= '0;
            rsp_ptr    <= '0;
            rd_ptr     <= '0;
            pend_cnt   <= '0;
            rdy_cnt    <= '0;
            cancel_cnt <= '0;
            fs_pc      <= reset_pc_init;
        end else begin
            if (req_fire) begin
                wr_ptr <= wr_ptr + flight_ptr_w'(1);
                fs_pc  <= next_pc;
            end
            if (kill) begin
                // drop everything older, keep a request issued this cycle
                rsp_ptr    <= wr_ptr;
                rd_ptr     <= wr_ptr;
                pend_cnt   <= flight_cnt_w'(req_fire);
                rdy_cnt    <= '0;
                cancel_cnt <= cancel_cnt + pend_cnt - flight_cnt_w'(inst_data_ok);
            end else begin
                rsp_ptr  <= rsp_ptr + flight_ptr_w'(rsp_live);
                rd_ptr   <= rd_ptr + flight_ptr_w'(pop);
                pend_cnt <= pend_cnt + flight_cnt_w'(req_fire) - flight_cnt_w'(rsp_live);
                rdy_cnt  <= rdy_cnt + flight_cnt_w'(rsp_live) - flight_cnt_w'(pop);
                if (inst_data_ok && cancel_cnt != '0)
                    cancel_cnt <= cancel_cnt - flight_cnt_w'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire)
            pc_q[wr_ptr] <= next_pc;
        if (rsp_live)
            inst_q[rsp_ptr] <= inst_rdata;
    end

    a_rsp_expected: assert property (
        @(posedge clk) disable iff (reset)
        inst_data_ok |-> (pend_cnt != '0) || (cancel_cnt != '0)
    ) else $error("inst_data_ok with no request outstanding");

    // decode side must see a steady word while it stalls
    a_ds_hold: assert property (
        @(posedge clk) disable iff (reset)
        (ds_valid && !ds_allowin) ##1 (!kill) |-> ds_valid && $stable(ds_pc) && $stable(ds_inst)
    ) else $error("decode outputs changed under stall");

endmodule

//--- verilog/inst_addr_map.sv
`timescale 1ns/1ps

// fixed mapping for instruction fetch, no TLB lookup
//   kseg0  0x8000_0000 .. 0x9fff_ffff  strip segment bits, cached
//   kseg1  0xa000_0000 .. 0xbfff_ffff  strip segment bits, uncached
//   other  passed through unchanged, cached
module inst_addr_map
    import fetch_pkg::*;
(
    input  logic [31:0] vaddr,
    output paddr_u      paddr,
    output logic        uncached
);

    logic in_kseg0;
    logic in_kseg1;
    logic unmapped;

    assign in_kseg0 = (vaddr >= kseg0_base) && (vaddr < kseg1_base);
    assign in_kseg1 = (vaddr >= kseg1_base) && (vaddr < kseg2_base);
    assign unmapped = in_kseg0 | in_kseg1;

    always_comb begin
        if (unmapped)
            paddr.raw = vaddr & ~seg_mask;   // both windows alias low 512 MB
        else
            paddr.raw = vaddr;
    end

    // only kseg1 bypasses the cache
    assign uncached = in_kseg1;

endmodule

//--- verilog/pre_if_stage.sv
`timescale 1ns/1ps

module pre_if_stage
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] fs_pc,          // last issued pc
    input  logic        fs_allowin,
    input  logic        br_stall,
    input  logic        br_taken,
    input  logic [31:0] br_target,
    input  logic        flush,
    input  logic        m1s_inst_eret,
    input  logic [31:0] cp0_epc,
    input  logic        mfc0_stall,
    input  logic        inst_addr_ok,
    output logic [31:0] next_pc,
    output logic        req_fire,
    output logic        inst_req,
    output logic        inst_op,
    output logic [19:0] inst_tag,
    output logic [ 7:0] inst_index,
    output logic [ 3:0] inst_offset,
    output logic        inst_uncached
);

    logic        req_en;        // low through reset
    logic        br_go;
    logic        redir_valid;   // buffered redirect waiting for an issue slot
    logic        flush_pend;    // buffered redirect came from flush or eret
    logic [31:0] redir_pc;
    logic [31:0] seq_pc;
    paddr_u      req_paddr;

    assign seq_pc = fs_pc + 32'd4;
    assign br_go  = br_taken & ~br_stall & ~mfc0_stall;

    // eret over flush over branch
    always_comb begin
        if (m1s_inst_eret)
            next_pc = cp0_epc;
        else if (flush)
            next_pc = exc_vector;
        else if (redir_valid && flush_pend)
            next_pc = redir_pc;        // older flush still owns the next slot
        else if (br_go)
            next_pc = br_target;       // follows the delay slot already fetched
        else if (redir_valid)
            next_pc = redir_pc;
        else
            next_pc = seq_pc;
    end

    always_ff @(posedge clk) begin
        if (reset)
            req_en <= 1'b0;
        else
            req_en <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            redir_valid <= 1'b0;
            flush_pend  <= 1'b0;
        end else if (req_fire) begin
            redir_valid <= 1'b0;       // consumed by this issue
            flush_pend  <= 1'b0;
        end else if (flush | m1s_inst_eret) begin
            redir_valid <= 1'b1;
            flush_pend  <= 1'b1;
        end else if (br_go & ~flush_pend) begin
            redir_valid <= 1'b1;
        end
    end

    // next_pc already holds this cycle's winner
    always_ff @(posedge clk) begin
        if (flush | m1s_inst_eret | (br_go & ~flush_pend))
            redir_pc <= next_pc;
    end

    // request held until accepted, address follows next_pc
    assign inst_req = req_en & fs_allowin;
    assign req_fire = inst_req & inst_addr_ok;
    assign inst_op  = 1'b0;            // read

    inst_addr_map u_addr_map (
        .vaddr    (next_pc),
        .paddr    (req_paddr),
        .uncached (inst_uncached)
    );

    assign inst_tag    = req_paddr.fields.tag;
    assign inst_index  = req_paddr.fields.index;
    assign inst_offset = req_paddr.fields.offset;

    // branch targets and epc come from later stages
    a_issue_aligned: assert property (
        @(posedge clk) disable iff (reset)
        req_fire |-> (next_pc[1:0] == 2'b00)
    ) else $error("fetch issued misaligned pc %h", next_pc);

endmodule
